/* bridgePkg.sv */
package bridgePkg;

    // Full 68040 data bus, four byte lanes
    typedef logic [31:0] busData;

    // One half of the data bus, used for the latched upper word and flipped lanes
    typedef logic [15:0] laneWord;

    // CPU size code as driven on SIZ1..SIZ0
    typedef logic [1:0] xferSize;

    // Address bits 1 and 0 of a transfer
    typedef logic [1:0] portOffset;

    localparam xferSize SizeLong = 2'b00;
    localparam xferSize SizeByte = 2'b01;
    localparam xferSize SizeWord = 2'b10;
    localparam xferSize SizeLine = 2'b11;

    // Word ports see the high word at offset 0 and the low word at offset 2
    localparam portOffset OffsetLow = 2'b00;
    localparam portOffset OffsetHigh = 2'b10;

    // Sequencer states for one CPU transfer
    typedef enum logic [2:0] {
        idle,
        directRun,
        firstWait,
        secondStart,
        secondWait
    } seqState;

endpackage

/* cycleDecode.sv */
module cycleDecode (
    input  logic                 CLK80,
    input  logic                 RESETn,
    input  logic                 cpuTsN,
    input  logic                 cpuRnW,
    input  bridgePkg::xferSize   cpuSize,
    input  bridgePkg::portOffset cpuAddr,
    input  logic                 wordPort,
    output logic                 reqValid,
    output logic                 reqRnW,
    output bridgePkg::portOffset reqOffset,
    output logic                 reqSplit,
    output logic                 reqFlip
);

    logic isLong;
    logic splitNext;
    logic flipNext;

    // A line transfer moves through the bridge as a plain long word
    always_comb begin
        case (cpuSize)
            bridgePkg::SizeLong, bridgePkg::SizeLine: isLong = 1'b1;
            bridgePkg::SizeByte, bridgePkg::SizeWord: isLong = 1'b0;
            default: isLong = 1'b0;
        endcase
    end

    // Long words to a 16-bit port need two Amiga sub-cycles
    assign splitNext = wordPort && isLong;

    // Byte or word at offset 2 of a word port lands on the upper lanes
    assign flipNext = wordPort && !isLong && cpuAddr[1];

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            reqValid <= 1'b0;
            reqRnW <= 1'b1;
            reqSplit <= 1'b0;
            reqFlip <= 1'b0;
        end else begin
            // One-clock pulse in the clock after the CPU transfer start
            reqValid <= !cpuTsN;
            if (!cpuTsN) begin
                reqRnW <= cpuRnW;
                reqSplit <= splitNext;
                reqFlip <= flipNext;
            end
        end
    end

    // Offset is held until the next transfer start
    always_ff @(posedge CLK80) begin
        if (!cpuTsN) begin
            reqOffset <= cpuAddr;
        end
    end

endmodule

/* cycleSequencer.sv */
module cycleSequencer (
    input  logic                 CLK80,
    input  logic                 RESETn,
    input  logic                 reqValid,
    input  logic                 reqSplit,
    input  bridgePkg::portOffset reqOffset,
    input  logic                 amigaTackN,
    output logic                 amigaTsN,
    output bridgePkg::portOffset amigaAddr,
    output logic                 cpuTaN,
    output logic                 splitActive,
    output logic                 secondHalf,
    output logic                 latchUpper
);

    bridgePkg::seqState state;
    logic ackSeen;
    logic taEnable;

    assign ackSeen = !amigaTackN;

    //////////////////////////////
    // Cycle state machine
    //////////////////////////////

    // A split transfer takes the cycle away from the CPU. The first sub-cycle moves
    // the high word at offset 0 and the second moves the low word at offset 2
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state <= bridgePkg::idle;
            amigaTsN <= 1'b1;
        end else begin
            // Transfer start is a single clock wide unless set below
            amigaTsN <= 1'b1;
            case (state)
                bridgePkg::idle: begin
                    if (reqValid) begin
                        amigaTsN <= 1'b0;
                        state <= reqSplit ? bridgePkg::firstWait : bridgePkg::directRun;
                    end
                end
                bridgePkg::directRun: begin
                    // The Amiga acknowledge also ends the CPU transfer
                    if (ackSeen) begin
                        state <= bridgePkg::idle;
                    end
                end
                bridgePkg::firstWait: begin
                    // Second start follows the first acknowledge by one clock
                    if (ackSeen) begin
                        amigaTsN <= 1'b0;
                        state <= bridgePkg::secondStart;
                    end
                end
                bridgePkg::secondStart: begin
                    // The target may answer in the start clock itself
                    state <= ackSeen ? bridgePkg::idle : bridgePkg::secondWait;
                end
                bridgePkg::secondWait: begin
                    if (ackSeen) begin
                        state <= bridgePkg::idle;
                    end
                end
                default: begin
                    state <= bridgePkg::idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Amiga address
    //////////////////////////////

    // Address is loaded together with each start and held through the sub-cycle
    always_ff @(posedge CLK80) begin
        if (state == bridgePkg::idle && reqValid) begin
            amigaAddr <= reqSplit ? bridgePkg::OffsetLow : reqOffset;
        end else if (state == bridgePkg::firstWait && ackSeen) begin
            amigaAddr <= bridgePkg::OffsetHigh;
        end
    end

    //////////////////////////////
    // Cycle termination
    //////////////////////////////

    // The first acknowledge of a split is hidden from the CPU
    assign taEnable = (state == bridgePkg::directRun)
                   || (state == bridgePkg::secondStart)
                   || (state == bridgePkg::secondWait);

    assign cpuTaN = taEnable ? amigaTackN : 1'b1;

    // Flags for the lane router
    assign splitActive = (state == bridgePkg::firstWait)
                      || (state == bridgePkg::secondStart)
                      || (state == bridgePkg::secondWait);

    assign secondHalf = (state == bridgePkg::secondStart)
                     || (state == bridgePkg::secondWait);

    // Upper word is valid on the Amiga bus in the clock of the first acknowledge
    assign latchUpper = (state == bridgePkg::firstWait) && ackSeen;

endmodule

/* laneRouter.sv */
module laneRouter (
    input  logic              CLK80,
    input  logic              RESETn,
    input  logic              reqRnW,
    input  logic              reqFlip,
    input  logic              splitActive,
    input  logic              secondHalf,
    input  logic              latchUpper,
    input  bridgePkg::busData cpuWriteData,
    input  bridgePkg::busData amigaReadData,
    output bridgePkg::busData cpuReadData,
    output bridgePkg::busData amigaWriteData,
    output logic              amigaRnW
);

    bridgePkg::laneWord upperLatch;
    bridgePkg::laneWord cpuUpperIn;
    bridgePkg::laneWord cpuLowerIn;
    bridgePkg::laneWord amigaUpperIn;
    bridgePkg::laneWord amigaLowerIn;
    bridgePkg::laneWord cpuUpperOut;
    bridgePkg::laneWord cpuLowerOut;
    bridgePkg::laneWord amigaUpperOut;
    logic flipLanes;
    logic useLatch;

    // Split the buses into their word halves
    assign cpuUpperIn = cpuWriteData[31:16];
    assign cpuLowerIn = cpuWriteData[15:0];
    assign amigaUpperIn = amigaReadData[31:16];
    assign amigaLowerIn = amigaReadData[15:0];

    // Word ports only use the upper lanes, so offset 2 data has to be moved there.
    // The second half of a split is an offset 2 word as well
    assign flipLanes = reqFlip || secondHalf;

    // The upper CPU word of a split read was taken in the first sub-cycle
    assign useLatch = reqRnW && splitActive;

    //////////////////////////////
    // Upper word latch
    //////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            upperLatch <= '0;
        end else if (latchUpper && reqRnW) begin
            upperLatch <= amigaUpperIn;
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    assign cpuUpperOut = useLatch ? upperLatch : amigaUpperIn;

    // Amiga upper word shows up at CPU offset 2 when flipped
    assign cpuLowerOut = flipLanes ? amigaUpperIn : amigaLowerIn;

    assign cpuReadData = {cpuUpperOut, cpuLowerOut};

    //////////////////////////////
    // Write path
    //////////////////////////////

    // CPU lower word goes out on the Amiga upper lanes when flipped
    assign amigaUpperOut = flipLanes ? cpuLowerIn : cpuUpperIn;

    // Lower lanes always pass through on writes
    assign amigaWriteData = {amigaUpperOut, cpuLowerIn};

    // Both sub-cycles of a split use the direction of the CPU transfer
    assign amigaRnW = reqRnW;

endmodule

/* busBridge.sv */
module busBridge (
    input  logic                 CLK80,
    input  logic                 RESETn,

    // 68040 side
    input  logic                 cpuTsN,
    input  logic                 cpuRnW,
    input  bridgePkg::xferSize   cpuSize,
    input  bridgePkg::portOffset cpuAddr,
    input  bridgePkg::busData    cpuWriteData,
    input  logic                 wordPort,
    output logic                 cpuTaN,
    output bridgePkg::busData    cpuReadData,

    // Amiga side
    output logic                 amigaTsN,
    output bridgePkg::portOffset amigaAddr,
    output logic                 amigaRnW,
    output bridgePkg::busData    amigaWriteData,
    input  logic                 amigaTackN,
    input  bridgePkg::busData    amigaReadData
);

    // Captured request, held until the next CPU start
    logic                 reqValid;
    logic                 reqRnW;
    bridgePkg::portOffset reqOffset;
    logic                 reqSplit;
    logic                 reqFlip;

    // Sub-cycle flags for the data lanes
    logic                 splitActive;
    logic                 secondHalf;
    logic                 latchUpper;

    cycleDecode decode (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .cpuTsN    (cpuTsN),
        .cpuRnW    (cpuRnW),
        .cpuSize   (cpuSize),
        .cpuAddr   (cpuAddr),
        .wordPort  (wordPort),
        .reqValid  (reqValid),
        .reqRnW    (reqRnW),
        .reqOffset (reqOffset),
        .reqSplit  (reqSplit),
        .reqFlip   (reqFlip)
    );

    cycleSequencer sequencer (
        .CLK80       (CLK80),
        .RESETn      (RESETn),
        .reqValid    (reqValid),
        .reqSplit    (reqSplit),
        .reqOffset   (reqOffset),
        .amigaTackN  (amigaTackN),
        .amigaTsN    (amigaTsN),
        .amigaAddr   (amigaAddr),
        .cpuTaN      (cpuTaN),
        .splitActive (splitActive),
        .secondHalf  (secondHalf),
        .latchUpper  (latchUpper)
    );

    laneRouter router (
        .CLK80          (CLK80),
        .RESETn         (RESETn),
        .reqRnW         (reqRnW),
        .reqFlip        (reqFlip),
        .splitActive    (splitActive),
        .secondHalf     (secondHalf),
        .latchUpper     (latchUpper),
        .cpuWriteData   (cpuWriteData),
        .amigaReadData  (amigaReadData),
        .cpuReadData    (cpuReadData),
        .amigaWriteData (amigaWriteData),
        .amigaRnW       (amigaRnW)
    );

endmodule

/* amigaPortModel.sv */
module amigaPortModel (
    input  logic                 CLK80,
    input  logic                 RESETn,
    input  logic                 amigaTsN,
    input  bridgePkg::portOffset amigaAddr,
    input  logic                 amigaRnW,
    input  bridgePkg::busData    amigaWriteData,
    input  logic                 wordPort,
    input  logic [1:0]           waitSel,
    output logic                 amigaTackN,
    output bridgePkg::busData    amigaReadData
);

    // Word port memory on the upper lanes, indexed by address bit 1
    bridgePkg::laneWord wordMem [0:1];

    // Full 32-bit port memory, also indexed by address bit 1
    bridgePkg::busData longMem [0:1];

    bridgePkg::portOffset addrHeld;
    logic rnWHeld;
    logic busy;
    logic [1:0] waitLeft;

    // Each start is answered with one acknowledge clock after 0 to 3 wait states.
    // The model has no byte strobes, so every write stores a whole lane word
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            amigaTackN <= 1'b1;
            amigaReadData <= '0;
            busy <= 1'b0;
        end else begin
            amigaTackN <= 1'b1;
            // Write data is taken from the clock of the acknowledge
            if (!amigaTackN && !rnWHeld) begin
                if (wordPort) begin
                    wordMem[addrHeld[1]] <= amigaWriteData[31:16];
                end else begin
                    longMem[addrHeld[1]] <= amigaWriteData;
                end
            end
            if (!amigaTsN) begin
                addrHeld <= amigaAddr;
                rnWHeld <= amigaRnW;
                waitLeft <= waitSel;
                busy <= 1'b1;
            end else if (busy && waitLeft != 2'd0) begin
                waitLeft <= waitLeft - 2'd1;
            end else if (busy) begin
                busy <= 1'b0;
                amigaTackN <= 1'b0;
                // A word port leaves its lower lanes floating, modelled as the inverted word
                if (rnWHeld && wordPort) begin
                    amigaReadData <= {wordMem[addrHeld[1]], ~wordMem[addrHeld[1]]};
                end else if (rnWHeld) begin
                    amigaReadData <= longMem[addrHeld[1]];
                end
            end
        end
    end

endmodule

/* busBridge_assertions.sv */
module busBridge_assertions (
    input logic               CLK80,
    input logic               RESETn,
    input logic               cpuTsN,
    input bridgePkg::xferSize cpuSize,
    input logic               wordPort,
    input logic               amigaTsN,
    input logic               amigaTackN,
    input logic               cpuTaN,
    input logic               reqRnW,
    input logic               reqFlip,
    input logic               splitActive,
    input bridgePkg::busData  cpuWriteData,
    input bridgePkg::busData  cpuReadData,
    input bridgePkg::busData  amigaWriteData,
    input bridgePkg::busData  amigaReadData
);

    // Running count of failed properties, read by the testbench after each test
    int assertFails = 0;

    // Amiga upper word as it stood at the first acknowledge of a split
    bridgePkg::laneWord firstUpper;

    // Amiga acknowledges still owed in the current CPU transfer
    logic [1:0] acksDue;

    // The first acknowledge of a split is the one that is hidden from the CPU
    always_ff @(posedge CLK80) begin
        if (splitActive && !amigaTackN && cpuTaN) begin
            firstUpper <= amigaReadData[31:16];
        end
    end

    // A long or line transfer to a word port takes two sub-cycles, all others one
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            acksDue <= 2'd0;
        end else if (!cpuTsN) begin
            if (wordPort && (cpuSize == bridgePkg::SizeLong
                             || cpuSize == bridgePkg::SizeLine)) begin
                acksDue <= 2'd2;
            end else begin
                acksDue <= 2'd1;
            end
        end else if (!amigaTackN && acksDue != 2'd0) begin
            acksDue <= acksDue - 2'd1;
        end
    end

    //////////////////////////////
    // Handshake
    //////////////////////////////

    assert property (@(posedge CLK80) disable iff (!RESETn) !amigaTsN |=> amigaTsN)
        else begin
            assertFails++;
            $error("amigaTsN stayed low for more than one clock");
        end

    assert property (@(posedge CLK80) disable iff (!RESETn)
        !cpuTaN |-> (!amigaTackN && acksDue == 2'd1))
        else begin
            assertFails++;
            $error("cpuTaN went low without the last Amiga acknowledge of the transfer");
        end

    assert property (@(posedge CLK80) disable iff (!RESETn)
        (!amigaTackN && acksDue == 2'd1) |-> !cpuTaN)
        else begin
            assertFails++;
            $error("Last Amiga acknowledge of the transfer did not reach cpuTaN");
        end

    //////////////////////////////
    // Data lanes
    //////////////////////////////

    assert property (@(posedge CLK80) disable iff (!RESETn)
        (!cpuTaN && splitActive && reqRnW) |-> cpuReadData[31:16] == firstUpper)
        else begin
            assertFails++;
            $error("Split read upper word differs from the first sub-cycle data");
        end

    assert property (@(posedge CLK80) disable iff (!RESETn)
        (!cpuTaN && reqFlip && reqRnW) |-> cpuReadData[15:0] == amigaReadData[31:16])
        else begin
            assertFails++;
            $error("Flipped read did not move the Amiga upper word to the CPU lower word");
        end

    assert property (@(posedge CLK80) disable iff (!RESETn)
        (!amigaTackN && reqFlip && !reqRnW) |-> amigaWriteData[31:16] == cpuWriteData[15:0])
        else begin
            assertFails++;
            $error("Flipped write did not move the CPU lower word to the Amiga upper word");
        end

endmodule

/* busBridgeTb.sv */
module busBridgeTb;

    localparam int Period = 40;
    localparam int FixedXfers = 16;
    localparam int RandomXfers = 40;
    // Every transfer is at most two Amiga sub-cycles of up to 8 clocks each
    localparam int WatchdogTime = (FixedXfers + RandomXfers + 2) * 2 * 8 * Period;

    logic CLK80;
    logic RESETn;
    logic cpuTsN;
    logic cpuRnW;
    bridgePkg::xferSize cpuSize;
    bridgePkg::portOffset cpuAddr;
    bridgePkg::busData cpuWriteData;
    logic wordPort;
    logic [1:0] waitSel;
    logic cpuTaN;
    bridgePkg::busData cpuReadData;
    logic amigaTsN;
    bridgePkg::portOffset amigaAddr;
    logic amigaRnW;
    bridgePkg::busData amigaWriteData;
    logic amigaTackN;
    bridgePkg::busData amigaReadData;

    // Reference copy of the target memories
    bridgePkg::laneWord refWord [0:1];
    bridgePkg::busData refLong [0:1];

    bridgePkg::portOffset startAddrs [$];
    integer seed;
    int taCount;
    int checkErrors;
    int testsRun;
    int testsFailed;
    int errorsAtStart;
    int assertsAtStart;
    string testName;

    busBridge uut (.*);

    amigaPortModel target (.*);

    bind busBridge busBridge_assertions checks (.*);

    initial begin
        CLK80 = 1'b0;
        forever #(Period / 2) CLK80 = ~CLK80;
    end

    // Bus monitors, sampled in mid-clock where the DUT outputs are settled
    always @(negedge CLK80) begin
        if (cpuTaN === 1'b0) begin
            taCount++;
        end
        if (amigaTsN === 1'b0) begin
            startAddrs.push_back(amigaAddr);
        end
    end

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
            checkErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = checkErrors;
        assertsAtStart = uut.checks.assertFails;
    endtask

    task automatic finishTest();
        int failures;
        failures = checkErrors - errorsAtStart + uut.checks.assertFails - assertsAtStart;
        testsRun++;
        if (failures == 0) begin
            $display("PASS %s", testName);
        end else begin
            testsFailed++;
            $display("FAIL %s: %0d failed checks", testName, failures);
        end
    endtask

    //////////////////////////////
    // CPU transfer
    //////////////////////////////

    // Starts and ends on a falling edge, expected data comes from the reference memories
    task automatic cpuTransfer(input logic rnW, input bridgePkg::xferSize size,
                               input bridgePkg::portOffset addr, input logic toWordPort);
        bridgePkg::busData data;
        bridgePkg::busData expected;
        bridgePkg::busData laneMask;
        logic split;
        int taBefore;
        split = toWordPort && (size == bridgePkg::SizeLong || size == bridgePkg::SizeLine);
        data = $random(seed);
        startAddrs.delete();
        taBefore = taCount;
        cpuTsN = 1'b0;
        cpuRnW = rnW;
        cpuSize = size;
        cpuAddr = addr;
        wordPort = toWordPort;
        cpuWriteData = data;
        @(negedge CLK80);
        cpuTsN = 1'b1;
        // New wait states every clock, so both halves of a split get their own
        while (cpuTaN !== 1'b0) begin
            waitSel = 2'($random(seed));
            @(negedge CLK80);
        end
        laneMask = 32'hffff_ffff;
        if (!toWordPort) begin
            expected = refLong[addr[1]];
        end else if (split) begin
            expected = {refWord[0], refWord[1]};
        end else if (addr[1]) begin
            expected = {16'h0000, refWord[1]};
            laneMask = 32'h0000_ffff;
        end else begin
            expected = {refWord[0], 16'h0000};
            laneMask = 32'hffff_0000;
        end
        if (rnW) begin
            checkValue("read data", expected, cpuReadData & laneMask);
        end else if (!toWordPort) begin
            refLong[addr[1]] = data;
        end else if (split) begin
            refWord[0] = data[31:16];
            refWord[1] = data[15:0];
        end else if (addr[1]) begin
            refWord[1] = data[15:0];
        end else begin
            refWord[0] = data[31:16];
        end
        @(negedge CLK80);
        checkValue("cpuTaN count", 1, taCount - taBefore);
        checkValue("amigaTsN count", split ? 2 : 1, startAddrs.size());
        if (split && startAddrs.size() == 2) begin
            checkValue("first split address", 0, startAddrs[0]);
            checkValue("second split address", 2, startAddrs[1]);
        end else if (!split && startAddrs.size() == 1) begin
            checkValue("amiga address", addr, startAddrs[0]);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic port;
        logic rnW;
        bridgePkg::xferSize size;
        bridgePkg::portOffset addr;
        seed = 32'h9d29_9d0e;
        RESETn = 1'b0;
        cpuTsN = 1'b1;
        cpuRnW = 1'b1;
        cpuSize = bridgePkg::SizeLong;
        cpuAddr = '0;
        cpuWriteData = '0;
        wordPort = 1'b0;
        waitSel = 2'd0;
        taCount = 0;
        checkErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (3) @(negedge CLK80);
        RESETn = 1'b1;

        startTest("reset");
        repeat (4) begin
            @(negedge CLK80);
            if (amigaTsN !== 1'b1 || cpuTaN !== 1'b1) begin
                $display("Error in %s: a handshake output left its idle level", testName);
                checkErrors++;
            end
        end
        finishTest();

        startTest("long 32-bit port");
        cpuTransfer(1'b0, bridgePkg::SizeLong, 2'd0, 1'b0);
        cpuTransfer(1'b0, bridgePkg::SizeLong, 2'd2, 1'b0);
        cpuTransfer(1'b1, bridgePkg::SizeLong, 2'd0, 1'b0);
        cpuTransfer(1'b1, bridgePkg::SizeLong, 2'd2, 1'b0);
        finishTest();

        startTest("word port lanes");
        cpuTransfer(1'b0, bridgePkg::SizeWord, 2'd2, 1'b1);
        cpuTransfer(1'b0, bridgePkg::SizeWord, 2'd0, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeWord, 2'd2, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeWord, 2'd0, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeByte, 2'd3, 1'b1);
        cpuTransfer(1'b0, bridgePkg::SizeByte, 2'd2, 1'b1);
        finishTest();

        startTest("split long read");
        cpuTransfer(1'b1, bridgePkg::SizeLong, 2'd0, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeLine, 2'd0, 1'b1);
        finishTest();

        startTest("split long write");
        cpuTransfer(1'b0, bridgePkg::SizeLong, 2'd0, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeWord, 2'd0, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeWord, 2'd2, 1'b1);
        cpuTransfer(1'b1, bridgePkg::SizeLong, 2'd0, 1'b1);
        finishTest();

        // Mixed ports, sizes and directions with random wait states
        startTest("random mix");
        for (int n = 0; n < RandomXfers; n++) begin
            port = 1'($random(seed));
            rnW = 1'($random(seed));
            size = port ? bridgePkg::xferSize'($random(seed)) : bridgePkg::SizeLong;
            addr = bridgePkg::portOffset'($random(seed));
            if (size != bridgePkg::SizeByte) begin
                addr[0] = 1'b0;
            end
            cpuTransfer(rnW, size, addr, port);
        end
        finishTest();

        $display("Tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testsRun, testsFailed, checkErrors, uut.checks.assertFails);
        if (testsFailed == 0 && checkErrors == 0 && uut.checks.assertFails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog against an Amiga side that never acknowledges
    initial begin
        #(WatchdogTime);
        $display("Timeout: a CPU transfer was never acknowledged");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sim.f */
bridgePkg.sv
cycleDecode.sv
cycleSequencer.sv
laneRouter.sv
busBridge.sv
amigaPortModel.sv
busBridge_assertions.sv
busBridgeTb.sv
